// ==== cache_to_dram_golden.txt ====
# name cache block_addr(hex word address) then 8 expected words (hex)
# Each word equals its word address, block_addr plus word index
single_c0 0 0000100 00000100 00000101 00000102 00000103 00000104 00000105 00000106 00000107
single_c1 1 0000240 00000240 00000241 00000242 00000243 00000244 00000245 00000246 00000247
single_c2 2 0001a08 00001a08 00001a09 00001a0a 00001a0b 00001a0c 00001a0d 00001a0e 00001a0f
single_c3 3 00ff000 000ff000 000ff001 000ff002 000ff003 000ff004 000ff005 000ff006 000ff007
all_c0 0 0000040 00000040 00000041 00000042 00000043 00000044 00000045 00000046 00000047
all_c1 1 0000c80 00000c80 00000c81 00000c82 00000c83 00000c84 00000c85 00000c86 00000c87
all_c2 2 0123450 00123450 00123451 00123452 00123453 00123454 00123455 00123456 00123457
all_c3 3 0ffffe0 00ffffe0 00ffffe1 00ffffe2 00ffffe3 00ffffe4 00ffffe5 00ffffe6 00ffffe7
rdy_c0 0 0000008 00000008 00000009 0000000a 0000000b 0000000c 0000000d 0000000e 0000000f
rdy_c1 1 0002010 00002010 00002011 00002012 00002013 00002014 00002015 00002016 00002017
rdy_c2 2 0a5a5a0 00a5a5a0 00a5a5a1 00a5a5a2 00a5a5a3 00a5a5a4 00a5a5a5 00a5a5a6 00a5a5a7
rdy_c3 3 0000ff8 00000ff8 00000ff9 00000ffa 00000ffb 00000ffc 00000ffd 00000ffe 00000fff
stall_c0 0 0000300 00000300 00000301 00000302 00000303 00000304 00000305 00000306 00000307
stall_c1 1 0000318 00000318 00000319 0000031a 0000031b 0000031c 0000031d 0000031e 0000031f
stall_c2 2 0777770 00777770 00777771 00777772 00777773 00777774 00777775 00777776 00777777
stall_c3 3 0100000 00100000 00100001 00100002 00100003 00100004 00100005 00100006 00100007

// ==== cache_to_dram_rd.sv ====
// Read path from the caches to a DRAM controller application interface
// Reads only, the controller must return data in command order
// No registers here, timing is that of the TX and RX blocks

`timescale 1ns/10ps

module cache_to_dram_rd (
  input  logic                                   clk_i,
  input  logic                                   rst_i,

  // Cache request lanes
  input  logic [dram_rd_cfg_pkg::NUM_CACHE-1:0]  dma_req_v_i,
  input  logic [dram_rd_cfg_pkg::NUM_CACHE-1:0][dram_app_pkg::ADDR_W-1:0] dma_req_addr_i,
  output logic [dram_rd_cfg_pkg::NUM_CACHE-1:0]  dma_req_ready_o,

  // Cache data lanes
  output logic [dram_rd_cfg_pkg::NUM_CACHE-1:0][dram_rd_cfg_pkg::DATA_WIDTH-1:0] dma_data_o,
  output logic [dram_rd_cfg_pkg::NUM_CACHE-1:0]  dma_data_v_o,
  input  logic [dram_rd_cfg_pkg::NUM_CACHE-1:0]  dma_data_ready_i,

  // Controller command
  output logic                                   app_en_o,
  output logic [2:0]                             app_cmd_o,
  output logic [dram_app_pkg::ADDR_W-1:0]        app_addr_o,
  input  logic                                   app_rdy_i,

  // Controller read data
  input  logic                                   app_rd_data_valid_i,
  input  logic [dram_rd_cfg_pkg::DATA_WIDTH-1:0] app_rd_data_i,
  input  logic                                   app_rd_data_end_i
);

  logic                                   tag_v;
  logic [dram_rd_cfg_pkg::CACHE_ID_W-1:0] tag_id;
  logic                                   tag_ready; // Tag FIFO has room

  cache_to_dram_tx tx (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .dma_req_v_i     (dma_req_v_i),
    .dma_req_addr_i  (dma_req_addr_i),
    .dma_req_ready_o (dma_req_ready_o),
    .app_en_o        (app_en_o),
    .app_cmd_o       (app_cmd_o),
    .app_addr_o      (app_addr_o),
    .app_rdy_i       (app_rdy_i),
    .tag_v_o         (tag_v),
    .tag_id_o        (tag_id),
    .tag_ready_i     (tag_ready)
  );

  cache_to_dram_rx rx (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .tag_v_i             (tag_v),
    .tag_id_i            (tag_id),
    .tag_ready_o         (tag_ready),
    .app_rd_data_valid_i (app_rd_data_valid_i),
    .app_rd_data_i       (app_rd_data_i),
    .app_rd_data_end_i   (app_rd_data_end_i),
    .dma_data_o          (dma_data_o),
    .dma_data_v_o        (dma_data_v_o),
    .dma_data_ready_i    (dma_data_ready_i)
  );

endmodule

// ==== cache_to_dram_rx.sv ====
// Buffers controller read data and hands each burst to the cache named by the tag head
// Relies on in-order return, so the tag queue order equals the data order
// The data FIFO holds every outstanding burst, controller data is never refused

`timescale 1ns/10ps

module cache_to_dram_rx (
  input  logic                                   clk_i,
  input  logic                                   rst_i,

  input  logic                                   tag_v_i,
  input  logic [dram_rd_cfg_pkg::CACHE_ID_W-1:0] tag_id_i,
  output logic                                   tag_ready_o,

  input  logic                                   app_rd_data_valid_i,
  input  logic [dram_rd_cfg_pkg::DATA_WIDTH-1:0] app_rd_data_i,
  input  logic                                   app_rd_data_end_i, // Unused, beats are counted

  output logic [dram_rd_cfg_pkg::NUM_CACHE-1:0][dram_rd_cfg_pkg::DATA_WIDTH-1:0] dma_data_o,
  output logic [dram_rd_cfg_pkg::NUM_CACHE-1:0]  dma_data_v_o,
  input  logic [dram_rd_cfg_pkg::NUM_CACHE-1:0]  dma_data_ready_i
);

  typedef logic [dram_rd_cfg_pkg::DATA_WIDTH-1:0] word_t;
  typedef logic [dram_rd_cfg_pkg::CACHE_ID_W-1:0] cache_id_t;

  word_t     data_head;
  logic      data_empty;
  logic      data_pop;

  cache_id_t tag_head;
  logic      tag_empty;
  logic      tag_full;
  logic      tag_pop;

  logic [dram_app_pkg::BURST_CNT_W-1:0] beat_cnt;
  logic                                 last_beat;
  logic                                 beat_avail;

  fifo_sync #(
    .DEPTH     (dram_rd_cfg_pkg::NUM_CACHE * dram_app_pkg::BURST_LEN),
    .payload_t (word_t)
  ) data_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .push_i      (app_rd_data_valid_i),
    .push_data_i (app_rd_data_i),
    .full_o      (),                                 // Sized so it cannot fill
    .pop_i       (data_pop),
    .pop_data_o  (data_head),
    .empty_o     (data_empty)
  );

  // One entry per outstanding burst
  fifo_sync #(
    .DEPTH     (dram_rd_cfg_pkg::NUM_CACHE),
    .payload_t (cache_id_t)
  ) tag_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .push_i      (tag_v_i),
    .push_data_i (tag_id_i),
    .full_o      (tag_full),
    .pop_i       (tag_pop),
    .pop_data_o  (tag_head),
    .empty_o     (tag_empty)
  );

  assign tag_ready_o = !tag_full;

  assign beat_avail = !data_empty && !tag_empty;
  assign data_pop   = beat_avail && dma_data_ready_i[tag_head];
  assign last_beat  = (beat_cnt == dram_app_pkg::BURST_CNT_W'(dram_app_pkg::BURST_LEN - 1));
  assign tag_pop    = data_pop && last_beat;         // Burst done, move to next owner

  // Data is broadcast, valid selects the owner
  always_comb begin
    for (int i = 0; i < dram_rd_cfg_pkg::NUM_CACHE; i++) begin
      dma_data_o[i]   = data_head;
      dma_data_v_o[i] = beat_avail && (tag_head == cache_id_t'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      beat_cnt <= '0;
    end else if (data_pop) begin
      beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
    end
  end

endmodule

// ==== cache_to_dram_tx.sv ====
// Picks one cache request round-robin and issues its block as read bursts
// Commands are offered only while the RX tag FIFO has room, and every accepted
// command pushes its cache index there in the same cycle

`timescale 1ns/10ps

module cache_to_dram_tx (
  input  logic                                clk_i,
  input  logic                                rst_i,

  input  logic [dram_rd_cfg_pkg::NUM_CACHE-1:0] dma_req_v_i,
  input  logic [dram_rd_cfg_pkg::NUM_CACHE-1:0][dram_app_pkg::ADDR_W-1:0] dma_req_addr_i,
  output logic [dram_rd_cfg_pkg::NUM_CACHE-1:0] dma_req_ready_o,

  output logic                                app_en_o,
  output logic [2:0]                          app_cmd_o,
  output logic [dram_app_pkg::ADDR_W-1:0]     app_addr_o,
  input  logic                                app_rdy_i,

  output logic                                tag_v_o,
  output logic [dram_rd_cfg_pkg::CACHE_ID_W-1:0] tag_id_o,
  input  logic                                tag_ready_i
);

  localparam int BCNT_W = (dram_app_pkg::BURSTS_PER_BLOCK > 1) ?
                          $clog2(dram_app_pkg::BURSTS_PER_BLOCK) : 1;

  typedef enum logic [1:0] {
    ST_INIT,                                         // One cycle after reset, no grants
    ST_IDLE,
    ST_ISSUE
  } tx_state_e;

  tx_state_e state;

  logic [dram_rd_cfg_pkg::CACHE_ID_W-1:0] rr_ptr;    // First cache to consider
  logic [dram_rd_cfg_pkg::CACHE_ID_W-1:0] cand_id;
  logic [dram_rd_cfg_pkg::CACHE_ID_W-1:0] grant_id;
  logic                                   grant_v;

  logic [dram_rd_cfg_pkg::CACHE_ID_W-1:0] id_r;
  logic [dram_app_pkg::ADDR_W-1:0]        addr_r;
  logic [BCNT_W-1:0]                      burst_cnt;

  logic req_fire;
  logic cmd_fire;
  logic last_burst;

  // Search starts at rr_ptr and wraps, first requester wins
  always_comb begin
    grant_v  = 1'b0;
    grant_id = '0;
    cand_id  = '0;
    for (int k = 0; k < dram_rd_cfg_pkg::NUM_CACHE; k++) begin
      cand_id = dram_rd_cfg_pkg::CACHE_ID_W'((int'(rr_ptr) + k) % dram_rd_cfg_pkg::NUM_CACHE);
      if (!grant_v && dma_req_v_i[cand_id]) begin
        grant_v  = 1'b1;
        grant_id = cand_id;
      end
    end
  end

  // Losing requesters see ready low, idle caches see it high
  always_comb begin
    for (int i = 0; i < dram_rd_cfg_pkg::NUM_CACHE; i++) begin
      dma_req_ready_o[i] = (state == ST_IDLE) &&
                           (!dma_req_v_i[i] || (grant_v && grant_id == i));
    end
  end

  assign req_fire   = (state == ST_IDLE) && grant_v;
  assign last_burst = (burst_cnt == BCNT_W'(dram_app_pkg::BURSTS_PER_BLOCK - 1));

  assign app_en_o   = (state == ST_ISSUE) && tag_ready_i;
  assign app_cmd_o  = dram_app_pkg::CMD_READ;
  assign app_addr_o = addr_r;
  assign cmd_fire   = app_en_o && app_rdy_i;

  assign tag_v_o  = cmd_fire;                        // Tag enters RX queue with the command
  assign tag_id_o = id_r;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state     <= ST_INIT;
      rr_ptr    <= '0;
      burst_cnt <= '0;
    end else begin
      case (state)
        ST_INIT: state <= ST_IDLE;
        ST_IDLE: begin
          if (req_fire) begin
            state     <= ST_ISSUE;
            burst_cnt <= '0;
            rr_ptr    <= (grant_id == dram_rd_cfg_pkg::CACHE_ID_W'(dram_rd_cfg_pkg::NUM_CACHE - 1))
                         ? '0 : grant_id + 1'b1;
          end
        end
        ST_ISSUE: begin
          if (cmd_fire) begin
            burst_cnt <= burst_cnt + 1'b1;
            if (last_burst) begin
              state <= ST_IDLE;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      id_r   <= grant_id;
      addr_r <= dma_req_addr_i[grant_id];
    end else if (cmd_fire) begin
      addr_r <= addr_r + dram_app_pkg::ADDR_W'(dram_app_pkg::BURST_ADDR_STEP);
    end
  end

endmodule

// ==== compile.f ====
dram_rd_cfg_pkg.sv
dram_app_pkg.sv
fifo_sync.sv
cache_to_dram_tx.sv
cache_to_dram_rx.sv
cache_to_dram_rd.sv
tb_rd_checker.sv
tb_cache_to_dram_rd.sv

// ==== dram_app_pkg.sv ====
// Controller application-interface constants for read commands
// Addresses are word addresses, one word per beat, no byte mapping

package dram_app_pkg;

  localparam int ADDR_W = 28;                        // app_addr width
  localparam int BURST_LEN = 4;                      // Beats returned per read command
  localparam int BURST_CNT_W = $clog2(BURST_LEN);    // Beat counter on the RX side

  // Commands needed to fetch one cache block
  localparam int BURSTS_PER_BLOCK = dram_rd_cfg_pkg::BLOCK_WORDS / BURST_LEN;

  // Consecutive bursts of a block sit BURST_LEN words apart
  localparam int BURST_ADDR_STEP = BURST_LEN;

  localparam logic [2:0] CMD_READ = 3'b001;          // app_cmd code for a read

endpackage

// ==== dram_rd_cfg_pkg.sv ====
// Cache-side sizes for the DRAM read path
// CACHE_ID_W must cover NUM_CACHE, and BLOCK_WORDS must be a whole number of bursts

package dram_rd_cfg_pkg;

  // Cache population
  localparam int NUM_CACHE = 4;                      // Caches sharing one controller
  localparam int CACHE_ID_W = $clog2(NUM_CACHE);     // Tag width carried to the RX side

  // Payload shape
  localparam int DATA_WIDTH = 32;                    // One controller beat per word
  localparam int BLOCK_WORDS = 8;                    // Words fetched per DMA request

endpackage

// ==== fifo_sync.sv ====
// Single-clock FIFO, head word valid whenever empty_o is low
// Pushing when full is dropped, callers must check full_o first
// Same-cycle push and pop is allowed at any fill level except a push when full

`timescale 1ns/10ps

module fifo_sync #(
  parameter int DEPTH = 4,
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,

  input  logic     push_i,
  input  payload_t push_data_i,
  output logic     full_o,

  input  logic     pop_i,
  output payload_t pop_data_o,
  output logic     empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic do_push;
  logic do_pop;

  assign full_o  = (count == CNT_W'(DEPTH));
  assign empty_o = (count == '0);

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign pop_data_o = mem[rd_ptr];                   // Fall-through head

  // Storage has no reset, entries only become visible through count
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                     // Both or neither, level unchanged
      endcase
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it, exit status 1 unless the run passes
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_cache_to_dram_rd \
  -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "TEST PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== tb_cache_to_dram_rd.sv ====
// Testbench for the cache to DRAM read path, stimulus from cache_to_dram_golden.txt
// Expects 16 golden lines in four groups of four, caches 0 to 3 in each group
// The DRAM model returns word address as data and answers in command order

`timescale 1ns/10ps

module tb_cache_to_dram_rd;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_TESTS = 16;
  localparam int NC = dram_rd_cfg_pkg::NUM_CACHE;
  localparam int DW = dram_rd_cfg_pkg::DATA_WIDTH;
  localparam int AW = dram_app_pkg::ADDR_W;

  logic                   clk_i = 0;
  logic                   rst_i;
  logic [NC-1:0]          dma_req_v_i;
  logic [NC-1:0][AW-1:0]  dma_req_addr_i;
  logic [NC-1:0]          dma_req_ready_o;
  logic [NC-1:0][DW-1:0]  dma_data_o;
  logic [NC-1:0]          dma_data_v_o;
  logic [NC-1:0]          dma_data_ready_i;
  logic                   app_en_o;
  logic [2:0]             app_cmd_o;
  logic [AW-1:0]          app_addr_o;
  logic                   app_rdy_i;
  logic                   app_rd_data_valid_i;
  logic [DW-1:0]          app_rd_data_i;
  logic                   app_rd_data_end_i;

  string         t_name [NUM_TESTS];
  int            t_cache [NUM_TESTS];
  logic [AW-1:0] t_addr [NUM_TESTS];
  logic [DW-1:0] t_words [NUM_TESTS][dram_rd_cfg_pkg::BLOCK_WORDS];
  int            n_tests = 0;

  integer        seed = 68195;
  integer        rnd;
  int            drop_pct = 25;                      // Chance of app_rdy_i low, percent
  int            cyc = 0;
  logic [AW-1:0] cmd_addr_q [$];
  int            cmd_due_q [$];
  logic [AW-1:0] cur_addr;
  int            beat = 0;
  bit            beat_active = 0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  cache_to_dram_rd DUT (.*);

  tb_rd_checker #(.CLK_PERIOD(CLK_PERIOD)) chk (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .dma_data_i       (dma_data_o),
    .dma_data_v_i     (dma_data_v_o),
    .dma_data_ready_i (dma_data_ready_i),
    .dma_req_ready_i  (dma_req_ready_o),
    .app_en_i         (app_en_o),
    .app_cmd_i        (app_cmd_o),
    .app_rdy_i        (app_rdy_i)
  );

  task automatic load_golden();
    int    fd;
    int    cnt;
    string line;
    fd = $fopen("cache_to_dram_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open cache_to_dram_golden.txt");
    end else begin
      while (!$feof(fd) && n_tests < NUM_TESTS) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h", t_name[n_tests],
                        t_cache[n_tests], t_addr[n_tests], t_words[n_tests][0],
                        t_words[n_tests][1], t_words[n_tests][2], t_words[n_tests][3],
                        t_words[n_tests][4], t_words[n_tests][5], t_words[n_tests][6],
                        t_words[n_tests][7]);
          if (cnt == 11) n_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Registers expected blocks, raises the requests and waits for every handshake
  task automatic start_group(input int first, input int count);
    logic [NC-1:0] waiting;
    logic [NC-1:0] fired;
    int            c;
    waiting = '0;
    for (int i = first; i < first + count; i++) begin
      for (int w = 0; w < dram_rd_cfg_pkg::BLOCK_WORDS; w++) begin
        chk.expect_word(t_cache[i], t_words[i][w]);
      end
      chk.expect_block(t_name[i], t_cache[i]);
    end
    @(negedge clk_i);
    for (int i = first; i < first + count; i++) begin
      c = t_cache[i];
      dma_req_v_i[c]    = 1'b1;
      dma_req_addr_i[c] = t_addr[i];
      waiting[c]        = 1'b1;
    end
    while (waiting != '0) begin
      #(CLK_PERIOD / 2 - 1);
      fired = dma_req_v_i & dma_req_ready_o;
      @(negedge clk_i);
      dma_req_v_i = dma_req_v_i & ~fired;
      waiting     = waiting & ~fired;
    end
  endtask

  task automatic wait_done();
    wait (chk.pending == 0);
    repeat (2) @(negedge clk_i);
  endtask

  // DRAM controller model, in-order reads with a random latency
  initial begin
    forever begin
      @(negedge clk_i);
      cyc++;
      if (!beat_active && cmd_addr_q.size() > 0 && cmd_due_q[0] <= cyc) begin
        cur_addr = cmd_addr_q.pop_front();
        void'(cmd_due_q.pop_front());
        beat        = 0;
        beat_active = 1;
      end
      app_rd_data_valid_i = beat_active;
      app_rd_data_end_i   = beat_active && (beat == dram_app_pkg::BURST_LEN - 1);
      app_rd_data_i       = DW'(cur_addr) + DW'(beat); // Word address as data
      if (beat_active) begin
        beat++;
        if (beat == dram_app_pkg::BURST_LEN) beat_active = 0;
      end
      rnd = $random(seed);
      app_rdy_i = !rst_i && (($unsigned(rnd) % 100) >= drop_pct);
      #(CLK_PERIOD / 2 - 1);
      if (app_en_o && app_rdy_i) begin
        rnd = $random(seed);
        cmd_addr_q.push_back(app_addr_o);
        cmd_due_q.push_back(cyc + 2 + int'($unsigned(rnd) % 5));
      end
    end
  end

  initial begin
    wait (n_tests > 0);
    #(n_tests * 200 * CLK_PERIOD);
    $display("timeout, the DUT stopped delivering data before all tests finished");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    rst_i               = 1'b1;
    dma_req_v_i         = '0;
    dma_req_addr_i      = '0;
    dma_data_ready_i    = '1;
    app_rdy_i           = 1'b0;
    app_rd_data_valid_i = 1'b0;
    app_rd_data_i       = '0;
    app_rd_data_end_i   = 1'b0;
    load_golden();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    if (n_tests == NUM_TESTS) begin
      for (int i = 0; i < 4; i++) begin               // One cache at a time
        start_group(i, 1);
        wait_done();
      end
      start_group(4, 4);                             // All caches at once
      wait_done();
      drop_pct = 60;                                 // Heavy command stalls
      start_group(8, 4);
      wait_done();
      drop_pct = 25;
      dma_data_ready_i[1] = 1'b0;                    // Cache 1 holds off its data
      start_group(12, 4);
      repeat (60) @(negedge clk_i);
      dma_data_ready_i[1] = 1'b1;
      wait_done();
    end else begin
      $display("golden file holds %0d usable lines, %0d needed", n_tests, NUM_TESTS);
    end
    chk.report();
    if (chk.fail_total == 0 && n_tests == NUM_TESTS) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== tb_rd_checker.sv ====
// Watches the cache data lanes and compares each block with its golden words
// Samples 1 ns before each rising edge, where DUT outputs and TB drives are settled

`timescale 1ns/10ps

module tb_rd_checker #(
  parameter int CLK_PERIOD = 40
) (
  input logic                                   clk_i,
  input logic                                   rst_i,
  input logic [dram_rd_cfg_pkg::NUM_CACHE-1:0][dram_rd_cfg_pkg::DATA_WIDTH-1:0] dma_data_i,
  input logic [dram_rd_cfg_pkg::NUM_CACHE-1:0]  dma_data_v_i,
  input logic [dram_rd_cfg_pkg::NUM_CACHE-1:0]  dma_data_ready_i,
  input logic [dram_rd_cfg_pkg::NUM_CACHE-1:0]  dma_req_ready_i,
  input logic                                   app_en_i,
  input logic [2:0]                             app_cmd_i,
  input logic                                   app_rdy_i
);

  logic [dram_rd_cfg_pkg::DATA_WIDTH-1:0] exp_word [dram_rd_cfg_pkg::NUM_CACHE][$];
  string exp_name [dram_rd_cfg_pkg::NUM_CACHE][$];
  int    order_q [$];                                // Cache of each block in grant order
  int    beat_idx [dram_rd_cfg_pkg::NUM_CACHE];
  bit    blk_bad [dram_rd_cfg_pkg::NUM_CACHE];
  int    pending = 0;
  int    pass_cnt = 0;
  int    fail_cnt = 0;
  int    other_err = 0;
  int    fail_total = 0;
  bit    idle_seen = 0;
  int    reset_err = 0;
  bit    stall_seen = 0;
  int    out_bursts = 0;                             // Bursts commanded but not fully delivered
  int    deliv_beats = 0;                            // Beats delivered of the oldest burst
  int    max_stall_out = 0;

  task automatic expect_word(input int c, input logic [dram_rd_cfg_pkg::DATA_WIDTH-1:0] w);
    exp_word[c].push_back(w);
  endtask

  task automatic expect_block(input string name, input int c);
    exp_name[c].push_back(name);
    order_q.push_back(c);
    pending++;
  endtask

  task automatic check_reset_state();
    if (rst_i) begin
      if (app_en_i === 1'b1 || (|dma_data_v_i) === 1'b1 || (|dma_req_ready_i) === 1'b1) begin
        $display("reset_state: an output is high while reset is asserted");
        reset_err++;
      end
    end else if (!idle_seen) begin
      if (|dma_req_ready_i) begin
        idle_seen = 1;
        if (dma_req_ready_i !== '1) begin
          $display("reset_state: request ready is not high for every cache when idle");
          reset_err++;
        end
        $display("test reset_state %s", (reset_err == 0) ? "passed" : "failed");
        if (reset_err == 0) pass_cnt++;
        else fail_cnt++;
      end else if (app_en_i || (|dma_data_v_i)) begin
        $display("reset_state: command or data valid before the first idle cycle");
        reset_err++;
      end
    end
  endtask

  // Every accepted command must be a read
  task automatic check_command();
    if (!rst_i && app_en_i && app_rdy_i && app_cmd_i !== dram_app_pkg::CMD_READ) begin
      $display("ERR app_cmd expected %h actual %h", dram_app_pkg::CMD_READ, app_cmd_i);
      other_err++;
    end
  endtask

  // Data returns burst by burst in command order, so one beat count covers all caches
  task automatic check_stall_limit();
    if (rst_i) begin
      out_bursts  = 0;
      deliv_beats = 0;
    end else begin
      if (app_en_i && app_rdy_i) out_bursts++;
      if (|(dma_data_v_i & dma_data_ready_i)) begin
        deliv_beats++;
        if (deliv_beats == dram_app_pkg::BURST_LEN) begin
          deliv_beats = 0;
          out_bursts--;
        end
      end
      if (|(dma_data_v_i & ~dma_data_ready_i)) begin
        stall_seen = 1;
        if (out_bursts > max_stall_out) max_stall_out = out_bursts;
      end
    end
  endtask

  task automatic check_beats();
    logic [dram_rd_cfg_pkg::DATA_WIDTH-1:0] exp;
    if ($countones(dma_data_v_i) > 1) begin
      $display("data valid is high for more than one cache at once");
      other_err++;
    end
    for (int c = 0; c < dram_rd_cfg_pkg::NUM_CACHE; c++) begin
      if (dma_data_v_i[c] && dma_data_ready_i[c]) begin
        if (exp_word[c].size() == 0) begin
          $display("extra beat for cache %0d with no block outstanding", c);
          other_err++;
        end else begin
          if (beat_idx[c] == 0) begin
            if (order_q.size() == 0 || order_q[0] != c) begin
              $display("block for cache %0d delivered out of grant order", c);
              blk_bad[c] = 1;
            end
            if (order_q.size() > 0) order_q.delete(0);
          end
          exp = exp_word[c].pop_front();
          if (dma_data_i[c] !== exp) begin
            $display("ERR %s beat %0d expected %h actual %h", exp_name[c][0], beat_idx[c],
                     exp, dma_data_i[c]);
            blk_bad[c] = 1;
          end
          beat_idx[c]++;
          if (beat_idx[c] == dram_rd_cfg_pkg::BLOCK_WORDS) begin
            $display("test %s %s", exp_name[c][0], blk_bad[c] ? "failed" : "passed");
            if (blk_bad[c]) fail_cnt++;
            else pass_cnt++;
            void'(exp_name[c].pop_front());
            beat_idx[c] = 0;
            blk_bad[c]  = 0;
            pending--;
          end
        end
      end
    end
  endtask

  task automatic report();
    if (!stall_seen || max_stall_out > dram_rd_cfg_pkg::NUM_CACHE) begin
      $display("test stall_limit failed, stall seen %0d, most bursts outstanding in a stall %0d",
               stall_seen, max_stall_out);
      fail_cnt++;
    end else begin
      $display("test stall_limit passed");
      pass_cnt++;
    end
    if (!idle_seen) begin
      $display("test reset_state failed, request ready never went high");
      fail_cnt++;
    end
    for (int c = 0; c < dram_rd_cfg_pkg::NUM_CACHE; c++) begin
      for (int k = 0; k < exp_name[c].size(); k++) begin
        $display("test %s failed, beats never arrived", exp_name[c][k]);
        fail_cnt++;
      end
    end
    $display("tests %0d, passed %0d, failed %0d, other errors %0d",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, other_err);
    fail_total = fail_cnt + other_err;
  endtask

  initial begin
    foreach (beat_idx[c]) beat_idx[c] = 0;
    foreach (blk_bad[c]) blk_bad[c] = 0;
    forever begin
      @(negedge clk_i);
      #(CLK_PERIOD / 2 - 1);
      check_reset_state();
      check_command();
      check_stall_limit();
      check_beats();
    end
  end

endmodule
